/* la_csr_config.svh */
`ifndef LA_CSR_CONFIG_SVH
`define LA_CSR_CONFIG_SVH

`define CSR_DATA_W 32
`define CSR_ADDR_W 14

// CSR numbers, one word each
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_EUEN   14'h002
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_CPUID  14'h020
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044
`define CSR_LLBCTL 14'h060

`define CRMD_IE_BIT 2
`define CRMD_DA_BIT 3
`define CRMD_PG_BIT 4
`define LLBCTL_KLO_BIT 2

`define CRMD_RESET    32'h0000_0008   // DA=1, PLV=0
`define ECFG_LIE_MASK 32'h0000_1bff   // LIE 12:11 and 9:0
`define CPUID_VALUE   32'h0000_0000

`define TCFG_EN_BIT       0
`define TCFG_PERIODIC_BIT 1

`endif

/* la_csr_pkg.sv */
`default_nettype none

`include "la_csr_config.svh"

package la_csr_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    // Retired CSR write from the pipeline
    typedef struct packed {
        logic                   wr_en;
        logic [`CSR_ADDR_W-1:0] addr;
        csr_data_t              data;
        logic                   llsc;   // Write comes from LL.W / SC.W
    } csr_write_t;

    typedef enum logic [4:0] {
        EXC_INT,
        EXC_PIL,
        EXC_PIS,
        EXC_PIF,
        EXC_PME,
        EXC_PPI,
        EXC_ADEF,
        EXC_ADEM,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE,
        EXC_IPE,
        EXC_FPD,
        EXC_FPE,
        EXC_TLBR
    } exc_cause_e;

endpackage

`default_nettype wire

/* csr_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface csr_ctrl_if;
    import la_csr_pkg::*;

    logic       take_exc;
    exc_cause_e exc_cause;
    csr_data_t  exc_pc;
    csr_data_t  exc_addr;
    logic       take_ertn;

    logic        crmd_ie;
    csr_data_t   eentry_va;
    csr_data_t   era_pc;
    logic [12:0] ecfg_lie;   // Bit 10 always zero
    logic [12:0] estat_is;

    modport ctrl (
        output take_exc, exc_cause, exc_pc, exc_addr, take_ertn,
        input  crmd_ie, eentry_va, era_pc, ecfg_lie, estat_is
    );

    modport csr (
        input  take_exc, exc_cause, exc_pc, exc_addr, take_ertn,
        output crmd_ie, eentry_va, era_pc, ecfg_lie, estat_is
    );

endinterface

`default_nettype wire

/* csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_csr_config.svh"

module csr_timer (
    input  wire                    clk,
    input  wire                    rst,
    input  la_csr_pkg::csr_write_t wr_i,
    output la_csr_pkg::csr_data_t  tcfg_o,
    output la_csr_pkg::csr_data_t  tval_o,
    output la_csr_pkg::csr_data_t  ticlr_o,
    output logic                   timer_irq_o
);
    import la_csr_pkg::*;

    csr_data_t tcfg;
    csr_data_t tval;
    logic      irq;

    logic      tcfg_wr;
    logic      ticlr_wr;
    logic      enabled;
    logic      count_end;
    csr_data_t init_val;

    assign tcfg_wr   = wr_i.wr_en && (wr_i.addr == `CSR_TCFG);
    assign ticlr_wr  = wr_i.wr_en && (wr_i.addr == `CSR_TICLR) && wr_i.data[0];
    assign enabled   = tcfg[`TCFG_EN_BIT];
    assign init_val  = {tcfg[`CSR_DATA_W-1:2], 2'b00};
    assign count_end = enabled && !tcfg_wr && (tval == csr_data_t'(1));   // Last tick before zero

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg <= '0;
            tval <= '1;
        end else if (tcfg_wr) begin
            tcfg <= wr_i.data;
            tval <= {wr_i.data[`CSR_DATA_W-1:2], 2'b00};
        end else if (enabled) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else if (tcfg[`TCFG_PERIODIC_BIT]) begin
                tval <= init_val;
            end
        end
    end

    // Sticky until software acks through TICLR
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (count_end) begin
            irq <= 1'b1;
        end else if (ticlr_wr) begin
            irq <= 1'b0;
        end
    end

    assign tcfg_o      = tcfg;
    assign tval_o      = tval;
    assign ticlr_o     = '0;
    assign timer_irq_o = irq;

endmodule

`default_nettype wire

/* csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_csr_config.svh"

module csr_regfile (
    input  wire                    clk,
    input  wire                    rst,
    csr_ctrl_if.csr                ctrl,
    input  la_csr_pkg::csr_write_t wr_i,
    input  wire                    rd_en_i,
    input  wire [13:0]             rd_addr_i,
    output la_csr_pkg::csr_data_t  rd_data_o,
    input  wire [7:0]              hwi_i,
    input  wire                    ipi_i,
    input  wire                    timer_irq_i,
    input  la_csr_pkg::csr_data_t  tcfg_i,
    input  la_csr_pkg::csr_data_t  tval_i,
    input  la_csr_pkg::csr_data_t  ticlr_i,
    output logic [1:0]             plv_o,
    output logic                   llbit_o
);
    import la_csr_pkg::*;

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t euen;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t era;
    csr_data_t badv;
    csr_data_t eentry;
    csr_data_t tid;
    csr_data_t save_q [4];
    logic      rollb;
    logic      klo;

    function automatic logic wr_hit(input logic [`CSR_ADDR_W-1:0] a);
        return wr_i.wr_en && (wr_i.addr == a);
    endfunction

    // Returns {EsubCode, Ecode}
    function automatic logic [14:0] cause_code(input exc_cause_e c);
        logic [5:0] ecode;
        logic [8:0] esub;
        esub = 9'd0;
        case (c)
            EXC_INT:  ecode = 6'h00;
            EXC_PIL:  ecode = 6'h01;
            EXC_PIS:  ecode = 6'h02;
            EXC_PIF:  ecode = 6'h03;
            EXC_PME:  ecode = 6'h04;
            EXC_PPI:  ecode = 6'h07;
            EXC_ADEF: ecode = 6'h08;
            EXC_ADEM: begin
                ecode = 6'h08;
                esub  = 9'd1;
            end
            EXC_ALE:  ecode = 6'h09;
            EXC_SYS:  ecode = 6'h0b;
            EXC_BRK:  ecode = 6'h0c;
            EXC_INE:  ecode = 6'h0d;
            EXC_IPE:  ecode = 6'h0e;
            EXC_FPD:  ecode = 6'h0f;
            EXC_FPE:  ecode = 6'h12;
            EXC_TLBR: ecode = 6'h3f;
            default:  ecode = 6'h00;
        endcase
        return {esub, ecode};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= `CRMD_RESET;
        end else if (ctrl.take_exc) begin
            crmd[1:0]          <= 2'b00;
            crmd[`CRMD_IE_BIT] <= 1'b0;
            if (ctrl.exc_cause == EXC_TLBR) begin   // Refill runs in direct mode
                crmd[`CRMD_DA_BIT] <= 1'b1;
                crmd[`CRMD_PG_BIT] <= 1'b0;
            end
        end else if (ctrl.take_ertn) begin
            crmd[1:0]          <= prmd[1:0];
            crmd[`CRMD_IE_BIT] <= prmd[2];
        end else if (wr_hit(`CSR_CRMD)) begin
            crmd[8:0] <= wr_i.data[8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (ctrl.take_exc) begin
            prmd[2:0] <= crmd[2:0];   // PIE, PPLV
        end else if (wr_hit(`CSR_PRMD)) begin
            prmd[2:0] <= wr_i.data[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            euen <= '0;
            ecfg <= '0;
        end else begin
            if (wr_hit(`CSR_EUEN)) begin
                euen[0] <= wr_i.data[0];   // FPE
            end
            if (wr_hit(`CSR_ECFG)) begin
                ecfg <= wr_i.data & `ECFG_LIE_MASK;
            end
        end
    end

    // IS lines are sampled every cycle, SWI bits come from software only
    always_ff @(posedge clk) begin
        if (rst) begin
            estat <= '0;
        end else begin
            estat[9:2] <= hwi_i;
            estat[11]  <= timer_irq_i;
            estat[12]  <= ipi_i;
            if (ctrl.take_exc) begin
                {estat[30:22], estat[21:16]} <= cause_code(ctrl.exc_cause);
            end
            if (wr_hit(`CSR_ESTAT)) begin
                estat[1:0] <= wr_i.data[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
            tid    <= `CPUID_VALUE;
        end else begin
            if (ctrl.take_exc) begin
                if (ctrl.exc_cause == EXC_SYS || ctrl.exc_cause == EXC_BRK) begin
                    era <= ctrl.exc_pc + 32'd4;
                end else begin
                    era <= ctrl.exc_pc;
                end
                case (ctrl.exc_cause)
                    EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI, EXC_ALE, EXC_TLBR:
                        badv <= ctrl.exc_addr;
                    EXC_ADEF: badv <= ctrl.exc_pc;   // Bad fetch address is the PC
                    default: ;
                endcase
            end else begin
                if (wr_hit(`CSR_ERA)) era <= wr_i.data;
                if (wr_hit(`CSR_BADV)) badv <= wr_i.data;
            end
            if (wr_hit(`CSR_EENTRY)) eentry[31:6] <= wr_i.data[31:6];
            if (wr_hit(`CSR_TID)) tid <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_hit(14'(`CSR_SAVE0 + i))) save_q[i] <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rollb <= 1'b0;
            klo   <= 1'b0;
        end else if (ctrl.take_ertn) begin
            if (klo) klo <= 1'b0;   // Keep LLbit across this one return
            else rollb <= 1'b0;
        end else if (wr_hit(`CSR_LLBCTL)) begin
            if (wr_i.llsc) begin
                rollb <= wr_i.data[0];   // LL sets, SC clears
            end else begin
                klo <= wr_i.data[`LLBCTL_KLO_BIT];
                if (wr_i.data[1]) rollb <= 1'b0;   // WCLLB
            end
        end
    end

    always_comb begin
        rd_data_o = '0;
        if (rd_en_i) begin
            case (rd_addr_i)
                `CSR_CRMD:   rd_data_o = crmd;
                `CSR_PRMD:   rd_data_o = prmd;
                `CSR_EUEN:   rd_data_o = euen;
                `CSR_ECFG:   rd_data_o = ecfg;
                `CSR_ESTAT:  rd_data_o = estat;
                `CSR_ERA:    rd_data_o = era;
                `CSR_BADV:   rd_data_o = badv;
                `CSR_EENTRY: rd_data_o = eentry;
                `CSR_CPUID:  rd_data_o = `CPUID_VALUE;
                `CSR_SAVE0:  rd_data_o = save_q[0];
                `CSR_SAVE1:  rd_data_o = save_q[1];
                `CSR_SAVE2:  rd_data_o = save_q[2];
                `CSR_SAVE3:  rd_data_o = save_q[3];
                `CSR_LLBCTL: rd_data_o = {29'd0, klo, 1'b0, rollb};
                `CSR_TID:    rd_data_o = tid;
                `CSR_TCFG:   rd_data_o = tcfg_i;
                `CSR_TVAL:   rd_data_o = tval_i;
                `CSR_TICLR:  rd_data_o = ticlr_i;
                default:     rd_data_o = '0;
            endcase
        end
    end

    assign ctrl.crmd_ie   = crmd[`CRMD_IE_BIT];
    assign ctrl.eentry_va = {eentry[31:6], 6'b0};
    assign ctrl.era_pc    = era;
    assign ctrl.ecfg_lie  = {ecfg[12:11], 1'b0, ecfg[9:0]};
    assign ctrl.estat_is  = {estat[12:11], 1'b0, estat[9:0]};

    assign plv_o   = crmd[1:0];
    assign llbit_o = rollb;

endmodule

`default_nettype wire

/* exc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    csr_ctrl_if.ctrl               ctrl,
    input  wire                    exc_valid_i,
    input  la_csr_pkg::exc_cause_e exc_cause_i,
    input  la_csr_pkg::csr_data_t  exc_pc_i,
    input  la_csr_pkg::csr_data_t  exc_addr_i,
    input  wire                    ertn_i,
    output logic                   redirect_o,
    output la_csr_pkg::csr_data_t  redirect_pc_o
);
    import la_csr_pkg::*;

    logic      int_pending;
    logic      take_exc;
    logic      take_ertn;
    logic      redirect_q;
    csr_data_t redirect_pc_q;

    // Global enable plus any locally enabled line
    assign int_pending = ctrl.crmd_ie && (|(ctrl.ecfg_lie & ctrl.estat_is));

    // Synchronous exception first, then interrupt, then return
    assign take_exc  = exc_valid_i || int_pending;
    assign take_ertn = ertn_i && !take_exc;

    assign ctrl.take_exc  = take_exc;
    assign ctrl.take_ertn = take_ertn;
    assign ctrl.exc_cause = exc_valid_i ? exc_cause_i : EXC_INT;
    assign ctrl.exc_pc    = exc_pc_i;
    assign ctrl.exc_addr  = exc_addr_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= take_exc || take_ertn;
        end
    end

    // ERA is sampled before the return updates anything
    always_ff @(posedge clk) begin
        if (take_exc) begin
            redirect_pc_q <= ctrl.eentry_va;
        end else if (take_ertn) begin
            redirect_pc_q <= ctrl.era_pc;
        end
    end

    assign redirect_o    = redirect_q;
    assign redirect_pc_o = redirect_pc_q;

endmodule

`default_nettype wire

/* csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_csr_config.svh"

module csr_unit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wr_en_i,
    input  wire [`CSR_ADDR_W-1:0]  wr_addr_i,
    input  la_csr_pkg::csr_data_t  wr_data_i,
    input  wire                    wr_llsc_i,
    input  wire                    rd_en_i,
    input  wire [`CSR_ADDR_W-1:0]  rd_addr_i,
    output la_csr_pkg::csr_data_t  rd_data_o,
    input  wire [7:0]              hwi_i,
    input  wire                    ipi_i,
    input  wire                    exc_valid_i,
    input  la_csr_pkg::exc_cause_e exc_cause_i,
    input  la_csr_pkg::csr_data_t  exc_pc_i,
    input  la_csr_pkg::csr_data_t  exc_addr_i,
    input  wire                    ertn_i,
    output logic                   redirect_o,
    output la_csr_pkg::csr_data_t  redirect_pc_o,
    output logic [1:0]             plv_o,
    output logic                   llbit_o,
    output logic                   timer_irq_o
);
    import la_csr_pkg::*;

    csr_write_t wr;
    csr_data_t  tcfg;
    csr_data_t  tval;
    csr_data_t  ticlr;
    logic       timer_irq;

    assign wr.wr_en = wr_en_i;
    assign wr.addr  = wr_addr_i;
    assign wr.data  = wr_data_i;
    assign wr.llsc  = wr_llsc_i;

    csr_ctrl_if ctrl_if ();

    csr_timer csr_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .ticlr_o     (ticlr),
        .timer_irq_o (timer_irq)
    );

    csr_regfile csr_regfile_inst (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl_if.csr),
        .wr_i        (wr),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .hwi_i       (hwi_i),
        .ipi_i       (ipi_i),
        .timer_irq_i (timer_irq),
        .tcfg_i      (tcfg),
        .tval_i      (tval),
        .ticlr_i     (ticlr),
        .plv_o       (plv_o),
        .llbit_o     (llbit_o)
    );

    exc_ctrl exc_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .ctrl          (ctrl_if.ctrl),
        .exc_valid_i   (exc_valid_i),
        .exc_cause_i   (exc_cause_i),
        .exc_pc_i      (exc_pc_i),
        .exc_addr_i    (exc_addr_i),
        .ertn_i        (ertn_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    assign timer_irq_o = timer_irq;

endmodule

`default_nettype wire

/* tb_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_csr_config.svh"

module tb_csr_unit;
    import la_csr_pkg::*;

    // Cycle budget per test, watchdog allows twice the sum
    localparam int T1_CYCLES = 40;
    localparam int T2_CYCLES = 16 * 8;
    localparam int T3_CYCLES = 4 * 10;
    localparam int T4_CYCLES = 3 * 16;
    localparam int T5_CYCLES = 80;
    localparam int T6_CYCLES = 40;
    localparam int WATCHDOG_CYCLES =
        2 * (5 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + T6_CYCLES);

    logic        clk;
    logic        rst;
    logic        wr_en;
    logic [13:0] wr_addr;
    csr_data_t   wr_data;
    logic        wr_llsc;
    logic        rd_en;
    logic [13:0] rd_addr;
    csr_data_t   rd_data;
    logic [7:0]  hwi;
    logic        ipi;
    logic        exc_valid;
    exc_cause_e  exc_cause;
    csr_data_t   exc_pc;
    csr_data_t   exc_addr;
    logic        ertn;
    logic        redirect;
    csr_data_t   redirect_pc;
    logic [1:0]  plv;
    logic        llbit;
    logic        timer_irq;

    // Reference copies of the CSRs
    logic [31:0] exp_crmd;
    logic [31:0] exp_prmd;
    logic [31:0] exp_ecfg;
    logic [31:0] exp_eentry;
    logic [31:0] exp_era;
    logic [31:0] exp_badv;
    logic [31:0] exp_save [4];
    logic [14:0] exp_code;
    logic        exp_llbit;
    logic        exp_klo;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;
    int          test_errors;
    string       test_name;

    csr_unit csr_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .wr_llsc_i     (wr_llsc),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (rd_data),
        .hwi_i         (hwi),
        .ipi_i         (ipi),
        .exc_valid_i   (exc_valid),
        .exc_cause_i   (exc_cause),
        .exc_pc_i      (exc_pc),
        .exc_addr_i    (exc_addr),
        .ertn_i        (ertn),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .plv_o         (plv),
        .llbit_o       (llbit),
        .timer_irq_o   (timer_irq)
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // {EsubCode, Ecode} per cause
    function automatic logic [14:0] expected_code(input exc_cause_e c);
        case (c)
            EXC_PIL:  return {9'd0, 6'h01};
            EXC_PIS:  return {9'd0, 6'h02};
            EXC_PIF:  return {9'd0, 6'h03};
            EXC_PME:  return {9'd0, 6'h04};
            EXC_PPI:  return {9'd0, 6'h07};
            EXC_ADEF: return {9'd0, 6'h08};
            EXC_ADEM: return {9'd1, 6'h08};
            EXC_ALE:  return {9'd0, 6'h09};
            EXC_SYS:  return {9'd0, 6'h0b};
            EXC_BRK:  return {9'd0, 6'h0c};
            EXC_INE:  return {9'd0, 6'h0d};
            EXC_IPE:  return {9'd0, 6'h0e};
            EXC_FPD:  return {9'd0, 6'h0f};
            EXC_FPE:  return {9'd0, 6'h12};
            EXC_TLBR: return {9'd0, 6'h3f};
            default:  return {9'd0, 6'h00};   // INT
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("error: %s = %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data, input logic llsc);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        wr_llsc = llsc;
        @(negedge clk);
        wr_en   = 1'b0;
        wr_llsc = 1'b0;
    endtask

    // Combinational read, settles well before the next rising edge
    task automatic read_csr(input logic [13:0] addr, output logic [31:0] data);
        rd_en   = 1'b1;
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic expect_csr(input string name, input logic [13:0] addr, input logic [31:0] want);
        logic [31:0] v;
        read_csr(addr, v);
        check_val(name, v, want);
    endtask

    task automatic raise_exception(input exc_cause_e cause, input logic [31:0] pc,
                                   input logic [31:0] addr);
        @(negedge clk);
        exc_valid = 1'b1;
        exc_cause = cause;
        exc_pc    = pc;
        exc_addr  = addr;
        @(negedge clk);
        exc_valid = 1'b0;
        exp_prmd = {29'd0, exp_crmd[2:0]};
        exp_crmd[2:0] = 3'b000;
        if (cause == EXC_TLBR) begin
            exp_crmd[`CRMD_DA_BIT] = 1'b1;
            exp_crmd[`CRMD_PG_BIT] = 1'b0;
        end
        exp_era = (cause == EXC_SYS || cause == EXC_BRK) ? pc + 32'd4 : pc;
        case (cause)
            EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI, EXC_ALE, EXC_TLBR: exp_badv = addr;
            EXC_ADEF: exp_badv = pc;
            default: ;
        endcase
        exp_code = expected_code(cause);
        check_true(redirect, "no redirect in the cycle after the exception");
        check_val("redirect_pc_o", redirect_pc, exp_eentry);
        check_val("plv_o", {30'd0, plv}, 32'd0);
        expect_csr("estat", `CSR_ESTAT, {1'b0, exp_code, 16'h0000});
        expect_csr("era", `CSR_ERA, exp_era);
        expect_csr("badv", `CSR_BADV, exp_badv);
        expect_csr("prmd", `CSR_PRMD, exp_prmd);
        expect_csr("crmd", `CSR_CRMD, exp_crmd);
        @(negedge clk);
        check_true(!redirect, "redirect held longer than one cycle after the exception");
    endtask

    task automatic do_return();
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        check_true(redirect, "no redirect in the cycle after the return");
        check_val("redirect_pc_o", redirect_pc, exp_era);
        exp_crmd[2:0] = exp_prmd[2:0];
        if (exp_klo) begin
            exp_klo = 1'b0;
        end else begin
            exp_llbit = 1'b0;
        end
        check_val("plv_o", {30'd0, plv}, {30'd0, exp_crmd[1:0]});
        check_val("llbit_o", {31'd0, llbit}, {31'd0, exp_llbit});
        expect_csr("crmd", `CSR_CRMD, exp_crmd);
        expect_csr("llbctl", `CSR_LLBCTL, {29'd0, exp_klo, 1'b0, exp_llbit});
        @(negedge clk);
        check_true(!redirect, "redirect held longer than one cycle after the return");
    endtask

    // is_bit is the ESTAT.IS position, 2..9 for hwi and 12 for ipi
    task automatic interrupt_case(input int is_bit, input logic ie, input logic [31:0] pc);
        logic        taken;
        logic [31:0] v;
        write_csr(`CSR_ECFG, 32'd1 << is_bit, 1'b0);
        exp_ecfg = 32'd1 << is_bit;
        write_csr(`CSR_CRMD, 32'h8 | {29'd0, ie, 2'b00}, 1'b0);
        exp_crmd = 32'h8 | {29'd0, ie, 2'b00};
        exc_pc = pc;
        @(negedge clk);
        if (is_bit == 12) begin
            ipi = 1'b1;
        end else begin
            hwi[is_bit - 2] = 1'b1;
        end
        taken = 1'b0;
        for (int c = 0; c < (ie ? 3 : 6) && !taken; c++) begin
            @(negedge clk);
            taken = redirect;
        end
        if (ie) begin
            check_true(taken, "no redirect within three cycles of an enabled interrupt line");
            check_val("redirect_pc_o", redirect_pc, exp_eentry);
            exp_prmd = {29'd0, exp_crmd[2:0]};
            exp_crmd[2:0] = 3'b000;
            exp_era = pc;
            exp_code = '0;
            read_csr(`CSR_ESTAT, v);
            check_val("estat.ecode", {17'd0, v[30:16]}, {17'd0, exp_code});
            expect_csr("prmd", `CSR_PRMD, exp_prmd);
            expect_csr("crmd", `CSR_CRMD, exp_crmd);
        end else begin
            check_true(!taken, "interrupt taken while CRMD.IE was clear");
        end
        hwi = '0;
        ipi = 1'b0;
        repeat (2) @(negedge clk);   // IS follows the lines one cycle late
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, test_name,
                     errors - test_errors);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] init;
        logic [31:0] pc_val;
        logic [31:0] addr_val;
        logic        found;
        clk = 1'b0;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_llsc = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        hwi = '0;
        ipi = 1'b0;
        exc_valid = 1'b0;
        exc_cause = EXC_INT;
        exc_pc = '0;
        exc_addr = '0;
        ertn = 1'b0;
        lfsr = 32'd88280;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        exp_crmd = `CRMD_RESET;
        exp_prmd = '0;
        exp_ecfg = '0;
        exp_eentry = '0;
        exp_era = '0;
        exp_badv = '0;
        exp_code = '0;
        exp_llbit = 1'b0;
        exp_klo = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset and read/write");
        expect_csr("crmd", `CSR_CRMD, `CRMD_RESET);
        expect_csr("tval", `CSR_TVAL, 32'hffff_ffff);
        check_val("plv_o", {30'd0, plv}, 32'd0);
        check_val("llbit_o", {31'd0, llbit}, 32'd0);
        check_val("redirect_o", {31'd0, redirect}, 32'd0);
        check_val("timer_irq_o", {31'd0, timer_irq}, 32'd0);
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, v);
            write_csr(14'(`CSR_SAVE0 + i), v, 1'b0);
            exp_save[i] = v;
        end
        for (int i = 0; i < 4; i++) begin
            expect_csr("save", 14'(`CSR_SAVE0 + i), exp_save[i]);
        end
        rand_bits(32, v);
        write_csr(`CSR_PRMD, v, 1'b0);
        exp_prmd = v & 32'h7;
        rand_bits(32, v);
        write_csr(`CSR_ECFG, v, 1'b0);
        exp_ecfg = v & `ECFG_LIE_MASK;
        rand_bits(32, v);
        write_csr(`CSR_EENTRY, v, 1'b0);
        exp_eentry = v & 32'hffff_ffc0;
        expect_csr("prmd", `CSR_PRMD, exp_prmd);
        expect_csr("ecfg", `CSR_ECFG, exp_ecfg);
        expect_csr("eentry", `CSR_EENTRY, exp_eentry);
        expect_csr("unknown csr", 14'h3ff, 32'd0);
        rd_en   = 1'b0;
        rd_addr = `CSR_CRMD;
        #1;
        check_val("rd_data_o with rd_en low", rd_data, 32'd0);
        write_csr(`CSR_ECFG, 32'd0, 1'b0);
        exp_ecfg = '0;
        end_test();

        begin_test("exception entry");
        for (int c = 0; c < 16; c++) begin
            rand_bits(5, v);
            write_csr(`CSR_CRMD, (v & 32'h17) | 32'h8, 1'b0);
            exp_crmd = (v & 32'h17) | 32'h8;
            rand_bits(32, pc_val);
            rand_bits(32, addr_val);
            raise_exception(exc_cause_e'(c), pc_val, addr_val);
        end
        end_test();

        begin_test("exception return");
        for (int i = 0; i < 4; i++) begin
            rand_bits(3, v);
            write_csr(`CSR_PRMD, v, 1'b0);
            exp_prmd = v & 32'h7;
            rand_bits(32, v);
            write_csr(`CSR_ERA, v, 1'b0);
            exp_era = v;
            do_return();
        end
        end_test();

        begin_test("interrupts");
        rand_bits(3, v);
        interrupt_case(int'(v) + 2, 1'b1, 32'h1c00_0100);
        interrupt_case(12, 1'b1, 32'h1c00_0200);
        interrupt_case(int'(v) + 2, 1'b0, 32'h1c00_0300);
        end_test();

        begin_test("timer");
        write_csr(`CSR_ECFG, 32'd0, 1'b0);
        exp_ecfg = '0;
        rand_bits(2, v);
        init = (v + 32'd2) << 2;   // 8 to 20
        write_csr(`CSR_TCFG, init | 32'h1, 1'b0);
        expect_csr("tval", `CSR_TVAL, init);
        @(negedge clk);
        expect_csr("tval", `CSR_TVAL, init - 32'd1);
        found = 1'b0;
        for (int c = 0; c < init + 3 && !found; c++) begin
            @(negedge clk);
            read_csr(`CSR_ESTAT, rd);
            found = rd[11];
        end
        check_true(found, "ESTAT timer bit not set within init+3 cycles");
        check_val("timer_irq_o", {31'd0, timer_irq}, 32'd1);
        repeat (2) @(negedge clk);
        expect_csr("tval", `CSR_TVAL, 32'd0);   // One-shot holds at zero
        write_csr(`CSR_TICLR, 32'd1, 1'b0);
        check_val("timer_irq_o", {31'd0, timer_irq}, 32'd0);
        @(negedge clk);
        read_csr(`CSR_ESTAT, rd);
        check_val("estat.ti", {31'd0, rd[11]}, 32'd0);
        expect_csr("ticlr", `CSR_TICLR, 32'd0);
        write_csr(`CSR_TCFG, init | 32'h3, 1'b0);
        found = 1'b0;
        for (int c = 0; c < init + 3 && !found; c++) begin
            @(negedge clk);
            read_csr(`CSR_TVAL, rd);
            found = (rd == 32'd0);
        end
        check_true(found, "periodic TVAL never reached zero");
        @(negedge clk);
        expect_csr("tval", `CSR_TVAL, init);
        write_csr(`CSR_TCFG, 32'd0, 1'b0);
        write_csr(`CSR_TICLR, 32'd1, 1'b0);
        check_val("timer_irq_o", {31'd0, timer_irq}, 32'd0);
        end_test();

        begin_test("llbit");
        write_csr(`CSR_PRMD, 32'd0, 1'b0);
        exp_prmd = '0;
        write_csr(`CSR_LLBCTL, 32'd1, 1'b1);   // LL.W
        exp_llbit = 1'b1;
        check_val("llbit_o", {31'd0, llbit}, 32'd1);
        write_csr(`CSR_LLBCTL, 32'd2, 1'b0);   // WCLLB
        exp_llbit = 1'b0;
        exp_klo = 1'b0;
        check_val("llbit_o", {31'd0, llbit}, 32'd0);
        write_csr(`CSR_LLBCTL, 32'd1, 1'b1);
        exp_llbit = 1'b1;
        do_return();
        write_csr(`CSR_LLBCTL, 32'd1, 1'b1);
        exp_llbit = 1'b1;
        write_csr(`CSR_LLBCTL, 32'd4, 1'b0);
        exp_klo = 1'b1;
        expect_csr("llbctl", `CSR_LLBCTL, {29'd0, exp_klo, 1'b0, exp_llbit});
        do_return();   // KLO consumed, LLbit kept
        do_return();
        end_test();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_unit.f */
+incdir+.
la_csr_pkg.sv
csr_ctrl_if.sv
csr_timer.sv
csr_regfile.sv
exc_ctrl.sv
csr_unit.sv
tb_csr_unit.sv
